/* Makefile */
SRCS := rv_core.f $(wildcard rtl/*.sv rtl/*.svh dv/*.sv dv/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vrv_core_tb: $(SRCS)
	verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o Vrv_core_tb

run: obj_dir/Vrv_core_tb
	obj_dir/Vrv_core_tb | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// ---------------------------------------------------------------------------
// Instruction encoders for the kept RV32I subset
// ---------------------------------------------------------------------------
function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input logic [2:0] f3,
                                 input reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
endfunction

function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                 input logic [2:0] f3, input reg_addr_t rd,
                                 input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

// SW only
function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                 input reg_addr_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OPC_STORE};
endfunction

// Forward branch by 8, skips exactly one instruction
function automatic word_t branch_skip(input reg_addr_t rs2, input reg_addr_t rs1,
                                      input logic [2:0] f3);
  return {7'b0, rs2, rs1, f3, 5'b01000, `RV_OPC_BRANCH};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
  return {imm, rd, `RV_OPC_LUI};
endfunction

// Distinct for every byte address
function automatic word_t fill_word(input int unsigned addr);
  return word_t'(addr) ^ 32'hC3A5_0000;
endfunction

// ---------------------------------------------------------------------------
// Random program generator
// ---------------------------------------------------------------------------
function automatic reg_addr_t random_reg();
  int unsigned v;
  v = $unsigned($random(seed));
  return reg_addr_t'(v % 31 + 1);
endfunction

function automatic logic [11:0] small_imm();
  return 12'($random(seed));
endfunction

// One word of the 32-word traffic area
function automatic logic [11:0] slot_offset();
  int unsigned v;
  v = $unsigned($random(seed)) % 32;
  return 12'(DATA_BASE + 4 * v);
endfunction

function automatic logic [2:0] alu_funct3(input int k);
  case (k)
    0:       return 3'b000;
    1:       return 3'b111;
    2:       return 3'b110;
    3:       return 3'b100;
    default: return 3'b010;
  endcase
endfunction

task automatic append_instr(input word_t ins);
  imem[prog_len] = ins;
  prog_len++;
endtask

// ADD AND OR XOR SLT, SUB, or the OP-IMM forms
task automatic add_alu_op(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
  int unsigned k;
  logic [2:0]  f3;
  k  = $unsigned($random(seed)) % 11;
  f3 = alu_funct3(int'(k % 5));
  if (k == 10) begin
    append_instr(r_type(7'h20, rs2, rs1, 3'b000, rd));
  end else if (k < 5) begin
    append_instr(r_type(7'h00, rs2, rs1, f3, rd));
  end else begin
    append_instr(i_type(small_imm(), rs1, f3, rd, `RV_OPC_OP_IMM));
  end
endtask

task automatic build_program(input bit end_illegal);
  int          i;
  reg_addr_t   rs;
  reg_addr_t   rt;
  logic [11:0] off;
  prog_len = 0;
  for (i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = fill_word(i * 4);
  end
  // Seed every register, ADDI reads the LUI result one slot later
  for (i = 1; i < 32; i++) begin
    append_instr(u_type(20'($random(seed)), reg_addr_t'(i)));
    append_instr(i_type(small_imm(), reg_addr_t'(i), 3'b000, reg_addr_t'(i),
                        `RV_OPC_OP_IMM));
  end
  for (i = 0; i < 40; i++) begin
    add_alu_op(random_reg(), random_reg(), random_reg());
  end
  // Fresh result stored at once, then loaded and used right away
  for (i = 0; i < 12; i++) begin
    rs  = random_reg();
    rt  = random_reg();
    off = slot_offset();
    append_instr(i_type(small_imm(), rs, 3'b000, rs, `RV_OPC_OP_IMM));
    append_instr(s_type(off, rs, 5'd0));
    if ($random(seed) % 4 == 0) begin
      off = slot_offset();
    end
    append_instr(i_type(off, 5'd0, 3'b010, rt, `RV_OPC_LOAD));
    add_alu_op(random_reg(), rt, rs);
  end
  // Equal operands half the time, BEQ and BNE alternate
  for (i = 0; i < 8; i++) begin
    rs = random_reg();
    rt = ($random(seed) % 2 == 0) ? rs : random_reg();
    append_instr(branch_skip(rt, rs, (i % 2 == 1) ? 3'b001 : 3'b000));
    // Shadow slot, a store so a wrong skip shows on the bus
    append_instr(s_type(slot_offset(), random_reg(), 5'd0));
    add_alu_op(random_reg(), rs, rt);
  end
  // Register dump above the traffic area
  for (i = 1; i < 32; i++) begin
    append_instr(s_type(12'(DATA_BASE + 128 + 4 * i), reg_addr_t'(i), 5'd0));
  end
  // JAL opcode is outside the subset
  append_instr(end_illegal ? 32'h0000_006F : 32'h0010_0073);
endtask

// ---------------------------------------------------------------------------
// Instruction set model
// ---------------------------------------------------------------------------
function automatic word_t ref_alu(input logic [2:0] f3, input logic sub, input word_t a,
                                  input word_t b);
  word_t r;
  case (f3)
    3'b000:  r = sub ? a - b : a + b;
    3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b100:  r = a ^ b;
    3'b110:  r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// Builds the ordered store list and the expected halt cause
task automatic iss_run();
  word_t x [0:31];
  word_t pc;
  word_t ins;
  word_t next;
  word_t a;
  word_t b;
  word_t addr;
  word_t res;
  logic  wr;
  bit    done;
  int    i;
  for (i = 0; i < 32; i++) begin
    x[i] = '0;
  end
  for (i = 0; i < DMEM_WORDS; i++) begin
    model_mem[i] = fill_word(i * 4);
  end
  exp_addr.delete();
  exp_data.delete();
  pc   = `RV_RESET_PC;
  done = 1'b0;
  while (!done) begin
    ins  = imem[pc[10:2]];
    a    = x[ins[19:15]];
    b    = x[ins[24:20]];
    next = pc + 4;
    wr   = 1'b1;
    res  = '0;
    case (ins[6:0])
      `RV_OPC_LUI:    res = {ins[31:12], 12'h000};
      `RV_OPC_OP_IMM: res = ref_alu(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
      `RV_OPC_OP:     res = ref_alu(ins[14:12], ins[30], a, b);
      `RV_OPC_LOAD: begin
        addr = a + {{20{ins[31]}}, ins[31:20]};
        res  = model_mem[addr[11:2]];
      end
      `RV_OPC_STORE: begin
        wr   = 1'b0;
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        model_mem[addr[11:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      `RV_OPC_BRANCH: begin
        wr = 1'b0;
        // funct3 bit 0 turns BEQ into BNE
        if ((a == b) != ins[12]) begin
          next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: begin
        // EBREAK ends cleanly, anything else traps
        wr       = 1'b0;
        done     = 1'b1;
        exp_trap = ins != 32'h0010_0073;
      end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      x[ins[11:7]] = res;
    end
    pc = next;
  end
endtask

`endif

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int CLK_NS     = 4;
  localparam int IMEM_WORDS = 512;
  localparam int DMEM_WORDS = 1024;
  localparam int DATA_BASE  = 'h400;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  imem_en;
  word_t imem_addr;
  word_t imem_rdata;
  logic  dmem_ren;
  word_t dmem_raddr;
  word_t dmem_rdata;
  logic  dmem_we;
  word_t dmem_waddr;
  word_t dmem_wdata;
  logic  ebreak;
  logic  trap;

  // Memories and the model's view
  word_t  imem [0:IMEM_WORDS-1];
  word_t  dmem [0:DMEM_WORDS-1];
  word_t  model_mem [0:DMEM_WORDS-1];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  logic   exp_trap;
  int     prog_len;
  integer seed = 47;

  // Checker state
  int     st_idx = 0;
  int     stores_seen = 0;
  int     value_errs = 0;
  int     other_errs = 0;
  logic   seen_fetch = 1'b0;
  longint deadline = 1000;
  logic   pend_we = 1'b0;
  word_t  pend_addr;
  word_t  pend_data;

  `include "rv_ref_model.svh"

  rv_core rv_core_i (
    .clk, .rst_n,
    .imem_en, .imem_addr, .imem_rdata,
    .dmem_ren, .dmem_raddr, .dmem_rdata,
    .dmem_we, .dmem_waddr, .dmem_wdata,
    .ebreak, .trap
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Same-cycle read on both memories
  // Data port returns zero unless a load is enabled
  assign imem_rdata = imem[imem_addr[10:2]];
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[11:2]] : '0;

  task automatic value_mismatch(input string sig, input word_t exp, input word_t act);
    value_errs++;
    $display("FAILED t=%0t %s expected %08h actual %08h", $time, sig, exp, act);
  endtask

  task automatic note_failure(input string msg);
    other_errs++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // ---------------------------------------------------------------------------
  // Store checker, sampled mid-cycle
  // ---------------------------------------------------------------------------
  always @(negedge clk) begin
    pend_we   = rst_n && dmem_we;
    pend_addr = dmem_waddr;
    pend_data = dmem_wdata;
    if (pend_we) begin
      assert (st_idx < exp_addr.size()) else
        note_failure($sformatf("store to %08h has no match in the model", dmem_waddr));
      if (st_idx < exp_addr.size()) begin
        assert (dmem_waddr == exp_addr[st_idx]) else
          value_mismatch("dmem_waddr", exp_addr[st_idx], dmem_waddr);
        assert (dmem_wdata == exp_data[st_idx]) else
          value_mismatch("dmem_wdata", exp_data[st_idx], dmem_wdata);
      end
      st_idx++;
      stores_seen++;
    end
  end

  // Write lands on the rising edge that ends the store cycle
  always @(posedge clk) begin
    if (pend_we) begin
      dmem[pend_addr[11:2]] = pend_data;
    end
  end

  // First fetch after reset
  always @(negedge clk) begin
    if (rst_n && imem_en && !seen_fetch) begin
      seen_fetch = 1'b1;
      assert (imem_addr == `RV_RESET_PC) else
        value_mismatch("imem_addr", `RV_RESET_PC, imem_addr);
    end
  end

  // Watchdog, budget set per program
  always @(negedge clk) begin
    if ($time > deadline) begin
      $display("Timeout: core did not halt, %0d value errors, %0d other errors",
               value_errs, other_errs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic reset_quiet_check();
    assert (!dmem_we && !dmem_ren && !ebreak && !trap) else
      note_failure("memory request or halt flag active in or right after reset");
  endtask

  // Entered at time 0 or 1 ns after a rising edge
  task automatic apply_reset();
    rst_n      = 1'b0;
    seen_fetch = 1'b0;
    @(posedge clk);
    @(negedge clk);
    reset_quiet_check();
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    reset_quiet_check();
  endtask

  task automatic run_program(input bit end_illegal);
    int i;
    build_program(end_illegal);
    iss_run();
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fill_word(i * 4);
    end
    st_idx   = 0;
    deadline = $time + prog_len * 8 * CLK_NS;
    apply_reset();
    while (!ebreak && !trap) begin
      @(negedge clk);
    end
    assert (ebreak == !exp_trap) else
      value_mismatch("ebreak", {31'b0, !exp_trap}, {31'b0, ebreak});
    assert (trap == exp_trap) else
      value_mismatch("trap", {31'b0, exp_trap}, {31'b0, trap});
    // Halt is sticky, the bus stays silent
    repeat (20) begin
      @(negedge clk);
      assert (ebreak == !exp_trap && trap == exp_trap) else
        note_failure("halt flags changed while the core was halted");
    end
    assert (st_idx == exp_addr.size()) else
      note_failure($sformatf("saw %0d stores, model expects %0d", st_idx, exp_addr.size()));
    @(posedge clk);
    #1;
  endtask

  initial begin
    rst_n = 1'b0;
    // Ends in EBREAK, then a fresh reset and a trapping run
    run_program(1'b0);
    run_program(1'b1);
    $display("Done: %0d stores checked, %0d value errors, %0d other errors",
             stores_seen, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Instruction memory, read data in the same cycle
  output logic  imem_en,
  output word_t imem_addr,
  input  word_t imem_rdata,
  // Data memory read port
  output logic  dmem_ren,
  output word_t dmem_raddr,
  input  word_t dmem_rdata,
  // Data memory write port, word stores only
  output logic  dmem_we,
  output word_t dmem_waddr,
  output word_t dmem_wdata,
  output logic  ebreak,
  output logic  trap
);

  // ------------------------------------------------------------------------
  // Stage to stage wiring
  // ------------------------------------------------------------------------
  logic      stall;
  logic      redirect;
  word_t     redirect_pc;
  logic      fetch_valid;
  word_t     fetch_pc;
  word_t     fetch_instr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      halt_req;
  logic      halt_is_trap;

  // Decoded slot, ID to EX
  rv_exec_if exec_bus ();

  rv_fetch fetch_i (
    .clk, .rst_n, .stall, .redirect, .redirect_pc,
    .imem_en, .imem_addr, .imem_rdata,
    .fetch_valid, .fetch_pc, .fetch_instr
  );

  rv_decode decode_i (
    .clk, .rst_n, .stall, .redirect,
    .fetch_valid, .fetch_pc, .fetch_instr,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .exec (exec_bus)
  );

  // Architectural registers sit beside decode
  rv_regfile regfile_i (
    .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wb_en, .wb_rd, .wb_data
  );

  rv_execute execute_i (
    .clk, .rst_n, .stall,
    .exec (exec_bus),
    .redirect, .redirect_pc,
    .dmem_ren, .dmem_raddr, .dmem_rdata,
    .dmem_we, .dmem_waddr, .dmem_wdata,
    .wb_en, .wb_rd, .wb_data,
    .halt_req, .halt_is_trap
  );

  rv_halt_ctrl halt_ctrl_i (
    .clk, .rst_n, .halt_req, .halt_is_trap, .stall, .ebreak, .trap
  );

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  logic      redirect,
  input  logic      fetch_valid,
  input  word_t     fetch_pc,
  input  word_t     fetch_instr,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  rv_exec_if.dec    exec
);

  // ------------------------------------------------------------------------
  // IF/ID register
  // ------------------------------------------------------------------------
  logic  id_valid;
  word_t id_pc;
  word_t id_instr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid <= 1'b0;
    end else if (!stall) begin
      // Taken branch in EX kills the slot fetched behind it
      id_valid <= fetch_valid && !redirect;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_pc    <= fetch_pc;
      id_instr <= fetch_instr;
    end
  end

  // ------------------------------------------------------------------------
  // Field split and immediates
  // ------------------------------------------------------------------------
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u;
  logic       zero_rs1;
  alu_op_t    f3_op;
  logic       f3_ok;

  assign opcode   = id_instr[6:0];
  assign funct3   = id_instr[14:12];
  assign funct7   = id_instr[31:25];
  assign rs1_addr = id_instr[19:15];
  assign rs2_addr = id_instr[24:20];

  assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
  assign imm_s = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
  assign imm_b = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
  assign imm_u = {id_instr[31:12], 12'h000};

  // Shared funct3 map for OP and OP-IMM, shifts and SLTU are not kept
  always_comb begin
    f3_ok = 1'b1;
    f3_op = ALU_ADD;
    case (funct3)
      3'b000:  f3_op = ALU_ADD;
      3'b010:  f3_op = ALU_SLT;
      3'b100:  f3_op = ALU_XOR;
      3'b110:  f3_op = ALU_OR;
      3'b111:  f3_op = ALU_AND;
      default: f3_ok = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------------
  // Control decode
  // ------------------------------------------------------------------------
  always_comb begin
    exec.alu_op     = ALU_ADD;
    exec.res_src    = RES_ALU;
    exec.use_imm    = 1'b1;
    exec.imm        = imm_i;
    exec.reg_write  = 1'b0;
    exec.mem_read   = 1'b0;
    exec.mem_write  = 1'b0;
    exec.is_branch  = 1'b0;
    exec.is_ebreak  = 1'b0;
    exec.is_illegal = 1'b0;
    zero_rs1        = 1'b0;
    case (opcode)
      `RV_OPC_LUI: begin
        // x0 + upper immediate
        exec.imm       = imm_u;
        exec.reg_write = 1'b1;
        zero_rs1       = 1'b1;
      end
      `RV_OPC_OP_IMM: begin
        exec.alu_op     = f3_op;
        exec.reg_write  = 1'b1;
        exec.is_illegal = !f3_ok;
      end
      `RV_OPC_OP: begin
        exec.use_imm    = 1'b0;
        exec.alu_op     = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : f3_op;
        exec.reg_write  = 1'b1;
        exec.is_illegal = !f3_ok || (funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 == 3'b000));
      end
      `RV_OPC_LOAD: begin
        exec.res_src    = RES_MEM;
        exec.reg_write  = 1'b1;
        exec.mem_read   = 1'b1;
        exec.is_illegal = funct3 != 3'b010;
      end
      `RV_OPC_STORE: begin
        exec.imm        = imm_s;
        exec.mem_write  = 1'b1;
        exec.is_illegal = funct3 != 3'b010;
      end
      `RV_OPC_BRANCH: begin
        // BEQ and BNE only
        exec.imm        = imm_b;
        exec.is_branch  = 1'b1;
        exec.is_illegal = funct3[2:1] != 2'b00;
      end
      `RV_OPC_SYSTEM: begin
        exec.is_ebreak  = id_instr[31:20] == 12'h001 && id_instr[19:7] == '0;
        exec.is_illegal = !exec.is_ebreak;
      end
      default: exec.is_illegal = 1'b1;
    endcase
    // Trapping slot must leave no side effect
    if (exec.is_illegal) begin
      exec.reg_write = 1'b0;
      exec.mem_read  = 1'b0;
      exec.mem_write = 1'b0;
      exec.is_branch = 1'b0;
    end
  end

  assign exec.valid     = id_valid;
  assign exec.pc        = id_pc;
  assign exec.rd        = id_instr[11:7];
  assign exec.branch_ne = funct3[0];
  assign exec.rs1_data  = zero_rs1 ? '0 : rs1_data;
  assign exec.rs2_data  = rs2_data;

endmodule

/* rtl/rv_exec_if.sv */
`timescale 1ns/1ps

// One decoded instruction, ID to EX
// No handshake, the global stall is the only flow control
interface rv_exec_if import rv_pkg::*; ();

  logic      valid;
  word_t     pc;
  alu_op_t   alu_op;
  res_src_t  res_src;
  logic      use_imm;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd;
  logic      reg_write;
  logic      mem_read;
  logic      mem_write;
  logic      is_branch;
  logic      branch_ne;
  logic      is_ebreak;
  logic      is_illegal;

  // Decode side drives everything
  modport dec (
    output valid, pc, alu_op, res_src, use_imm, imm, rs1_data, rs2_data, rd,
    output reg_write, mem_read, mem_write, is_branch, branch_ne, is_ebreak, is_illegal
  );

  // Execute side only reads
  modport exe (
    input valid, pc, alu_op, res_src, use_imm, imm, rs1_data, rs2_data, rd,
    input reg_write, mem_read, mem_write, is_branch, branch_ne, is_ebreak, is_illegal
  );

endinterface

/* rtl/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  rv_exec_if.exe    exec,
  output logic      redirect,
  output word_t     redirect_pc,
  output logic      dmem_ren,
  output word_t     dmem_raddr,
  input  word_t     dmem_rdata,
  output logic      dmem_we,
  output word_t     dmem_waddr,
  output word_t     dmem_wdata,
  output logic      wb_en,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      halt_req,
  output logic      halt_is_trap
);

  // Slot counts only while the core runs
  // Younger work caught behind a halt stays inert
  logic  active;
  word_t op_b;
  word_t alu_res;
  logic  rs_eq;

  assign active = exec.valid && !stall;
  assign op_b   = exec.use_imm ? exec.imm : exec.rs2_data;

  // ------------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------------
  always_comb begin
    case (exec.alu_op)
      ALU_SUB: alu_res = exec.rs1_data - op_b;
      ALU_AND: alu_res = exec.rs1_data & op_b;
      ALU_OR:  alu_res = exec.rs1_data | op_b;
      ALU_XOR: alu_res = exec.rs1_data ^ op_b;
      ALU_SLT: alu_res = word_t'($signed(exec.rs1_data) < $signed(op_b));
      default: alu_res = exec.rs1_data + op_b;
    endcase
  end

  // Branch resolves here, one bubble on taken
  assign rs_eq       = exec.rs1_data == exec.rs2_data;
  assign redirect    = active && exec.is_branch && (rs_eq ^ exec.branch_ne);
  assign redirect_pc = exec.pc + exec.imm;

  // Loads and stores address through the ALU adder
  assign dmem_ren   = active && exec.mem_read;
  assign dmem_raddr = alu_res;
  assign dmem_we    = active && exec.mem_write;
  assign dmem_waddr = alu_res;
  assign dmem_wdata = exec.rs2_data;

  assign halt_req     = active && (exec.is_ebreak || exec.is_illegal);
  assign halt_is_trap = exec.is_illegal;

  // ------------------------------------------------------------------------
  // WB register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_en <= 1'b0;
    end else if (!stall) begin
      wb_en <= active && exec.reg_write && exec.rd != '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_rd   <= exec.rd;
      wb_data <= (exec.res_src == RES_MEM) ? dmem_rdata : alu_res;
    end
  end

  // One port pair per slot, load and store never share a cycle
  a_no_rw_overlap : assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_ren && dmem_we));

endmodule

/* rtl/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall,
  input  logic  redirect,
  input  word_t redirect_pc,
  output logic  imem_en,
  output word_t imem_addr,
  input  word_t imem_rdata,
  output logic  fetch_valid,
  output word_t fetch_pc,
  output word_t fetch_instr
);

  word_t pc;
  // Low for the reset cycles, then fetch runs
  logic  fetch_on;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= `RV_RESET_PC;
      fetch_on <= 1'b0;
    end else begin
      fetch_on <= 1'b1;
      // Halt freezes the PC for good
      if (!stall) begin
        if (redirect) begin
          pc <= redirect_pc;
        end else if (imem_en) begin
          pc <= pc + `RV_XLEN'd4;
        end
      end
    end
  end

  // Memory answers in the same cycle
  assign imem_en     = fetch_on && !stall;
  assign imem_addr   = pc;
  assign fetch_valid = imem_en;
  assign fetch_pc    = pc;
  assign fetch_instr = imem_rdata;

  // Sequential and branch targets both keep word alignment
  a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    imem_en |-> imem_addr[1:0] == 2'b00);

endmodule

/* rtl/rv_halt_ctrl.sv */
`timescale 1ns/1ps

module rv_halt_ctrl import rv_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic halt_req,
  input  logic halt_is_trap,
  output logic stall,
  output logic ebreak,
  output logic trap
);

  halt_state_t state;
  halt_state_t state_next;
  logic        take_halt;

  assign take_halt = (state == HS_RUN) && halt_req;

  always_comb begin
    state_next = state;
    if (take_halt) begin
      state_next = HS_HALTED;
    end
  end

  // Flags latch at the halting edge and hold until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= HS_RUN;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      state <= state_next;
      if (take_halt) begin
        ebreak <= !halt_is_trap;
        trap   <= halt_is_trap;
      end
    end
  end

  assign stall = (state == HS_HALTED);

  // Execute goes quiet once the stall is up
  a_no_req_halted : assert property (@(posedge clk) disable iff (!rst_n)
    stall |-> !halt_req);

endmodule

/* rtl/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and register index widths
`define RV_XLEN      32
`define RV_REG_AW    5
// First fetch address out of reset
`define RV_RESET_PC  32'h0000_0000

// Major opcode field values, instr[6:0]
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_OP      7'b0110011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_SYSTEM  7'b1110011

`endif

/* rtl/rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

  // ------------------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------------------

  // Data word, byte address or raw instruction
  typedef logic [`RV_XLEN-1:0] word_t;

  // Architectural register index
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // ------------------------------------------------------------------------
  // Control encodings
  // ------------------------------------------------------------------------

  // ALU operations of the kept OP and OP-IMM subset
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_SLT
  } alu_op_t;

  // Write-back source select
  typedef enum logic {
    RES_ALU, RES_MEM
  } res_src_t;

  // Core run state
  // Halted only leaves through reset
  typedef enum logic {
    HS_RUN, HS_HALTED
  } halt_state_t;

endpackage

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      wb_en,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data
);

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Write-through so decode never waits on the WB slot
  function automatic word_t read_port(input reg_addr_t addr);
    word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (wb_en && wb_rd == addr) begin
      val = wb_data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // Execute drops writes to x0 before they reach the WB port
  a_no_x0_write : assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |-> wb_rd != '0);

endmodule

/* rv_core.f */
+incdir+rtl
+incdir+dv
rtl/rv_pkg.sv
rtl/rv_exec_if.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_halt_ctrl.sv
rtl/rv_core.sv
dv/rv_core_tb.sv
